// File: rtl/depth_post_settings.svh
`ifndef DEPTH_POST_SETTINGS_SVH
`define DEPTH_POST_SETTINGS_SVH

////////////////////////////////////////////////////////////
// host command layout
// 16-bit address then 32-bit data with the msb first on the link
`define DP_CMD_BYTES 6

// register map of the constants file
`define DP_ADDR_CONFIDENCE 16'h0001
`define DP_ADDR_ROI_WIDTH  16'h0002
`define DP_ADDR_ROI_HEIGHT 16'h0003

////////////////////////////////////////////////////////////
// reset values
`define DP_ROI_WIDTH_DEFAULT  16'd400
`define DP_ROI_HEIGHT_DEFAULT 16'd400
`define DP_CONF_DEFAULT       16'h0000

// depth code for pixels that fail the confidence test
`define DP_Z_INVALID 16'h7FFF

`endif

// File: rtl/depth_post_pkg.sv
package depth_post_pkg;

    ////////////////////////////////////////////////////////////
    // command path
    // register address carried in a host command
    typedef logic [15:0] cmd_addr_t;

    // command payload whose low half feeds the registers
    typedef logic [31:0] cmd_data_t;

    // one byte from the host link
    typedef logic [7:0] link_byte_t;

    ////////////////////////////////////////////////////////////
    // pixel path
    // raw half-precision pattern for depth or confidence
    typedef logic [15:0] fp16_t;

    // column or row index and region size
    typedef logic [15:0] coord_t;

    // tracker waits for the first frame start before counting
    typedef enum logic {
        TRK_IDLE = 1'b0,
        TRK_RUN  = 1'b1
    } track_state_e;

endpackage

// File: rtl/command_word_assembler.sv
`include "depth_post_settings.svh"

module command_word_assembler (
    input  logic                       core_clk,
    input  logic                       sys_reset,
    input  depth_post_pkg::link_byte_t link_byte_i,
    input  logic                       link_strobe_i,
    output depth_post_pkg::cmd_addr_t  cmd_addr_o,
    output depth_post_pkg::cmd_data_t  cmd_data_o,
    output logic                       cmd_strobe_o
);

    localparam int CMD_BYTES = `DP_CMD_BYTES;
    localparam int CNT_W     = $clog2(CMD_BYTES);
    localparam int BYTE_W    = $bits(depth_post_pkg::link_byte_t);
    localparam int ADDR_W    = $bits(depth_post_pkg::cmd_addr_t);
    localparam int DATA_W    = $bits(depth_post_pkg::cmd_data_t);
    localparam int WORD_W    = CMD_BYTES * BYTE_W;

    logic [WORD_W-1:0] shift_q;
    logic [CNT_W-1:0]  byte_cnt_q;
    logic              last_byte;

    assign last_byte = link_strobe_i && (byte_cnt_q == CNT_W'(CMD_BYTES - 1));

    ////////////////////////////////////////////////////////////
    // byte capture
    // first byte received ends up in the top byte of the word
    always_ff @(posedge core_clk) begin
        if (link_strobe_i) begin
            shift_q <= {shift_q[WORD_W-BYTE_W-1:0], link_byte_i};
        end
    end

    // word stays put until the next byte arrives, so it is
    // stable while the strobe is high
    assign cmd_addr_o = shift_q[WORD_W-1 -: ADDR_W];
    assign cmd_data_o = shift_q[DATA_W-1:0];

    ////////////////////////////////////////////////////////////
    // byte counter and command strobe
    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            byte_cnt_q   <= '0;
            cmd_strobe_o <= 1'b0;
        end else begin
            cmd_strobe_o <= last_byte;
            if (last_byte) begin
                byte_cnt_q <= '0;
            end else if (link_strobe_i) begin
                byte_cnt_q <= byte_cnt_q + 1'b1;
            end
        end
    end

    // count wraps before it could reach a full command
    a_byte_cnt_range: assert property (
        @(posedge core_clk) disable iff (sys_reset)
        byte_cnt_q < CNT_W'(CMD_BYTES)
    );

endmodule

// File: rtl/constants_regfile.sv
`include "depth_post_settings.svh"

module constants_regfile (
    input  logic                      core_clk,
    input  logic                      sys_reset,
    input  depth_post_pkg::cmd_addr_t cmd_addr_i,
    input  depth_post_pkg::cmd_data_t cmd_data_i,
    input  logic                      cmd_strobe_i,
    output depth_post_pkg::fp16_t     conf_threshold_o,
    output depth_post_pkg::coord_t    roi_width_o,
    output depth_post_pkg::coord_t    roi_height_o
);

    depth_post_pkg::fp16_t  conf_threshold_q;
    depth_post_pkg::coord_t roi_width_q;
    depth_post_pkg::coord_t roi_height_q;

    // every register is 16 bits wide
    logic [15:0] wr_value;

    assign wr_value = cmd_data_i[15:0];

    ////////////////////////////////////////////////////////////
    // command decode
    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            conf_threshold_q <= `DP_CONF_DEFAULT;
            roi_width_q      <= `DP_ROI_WIDTH_DEFAULT;
            roi_height_q     <= `DP_ROI_HEIGHT_DEFAULT;
        end else if (cmd_strobe_i) begin
            case (cmd_addr_i)
                `DP_ADDR_CONFIDENCE: begin
                    conf_threshold_q <= wr_value;
                end
                // zero writes are dropped so the tracker always has a region to wrap in
                `DP_ADDR_ROI_WIDTH: begin
                    if (wr_value != '0) begin
                        roi_width_q <= wr_value;
                    end
                end
                `DP_ADDR_ROI_HEIGHT: begin
                    if (wr_value != '0) begin
                        roi_height_q <= wr_value;
                    end
                end
                default: begin
                    // unknown address leaves everything unchanged
                end
            endcase
        end
    end

    assign conf_threshold_o = conf_threshold_q;
    assign roi_width_o      = roi_width_q;
    assign roi_height_o     = roi_height_q;

    ////////////////////////////////////////////////////////////
    // checks
    // region stays non-empty across any command sequence
    a_roi_nonzero: assert property (
        @(posedge core_clk) disable iff (sys_reset)
        (roi_width_q != '0) && (roi_height_q != '0)
    );

endmodule

// File: rtl/pixel_coord_tracker.sv
module pixel_coord_tracker (
    input  logic                   core_clk,
    input  logic                   sys_reset,
    input  logic                   pix_valid_i,
    input  logic                   pix_sof_i,
    input  depth_post_pkg::fp16_t  pix_z_i,
    input  depth_post_pkg::fp16_t  pix_c_i,
    input  depth_post_pkg::coord_t roi_width_i,
    input  depth_post_pkg::coord_t roi_height_i,
    output logic                   trk_valid_o,
    output depth_post_pkg::coord_t trk_col_o,
    output depth_post_pkg::coord_t trk_row_o,
    output depth_post_pkg::fp16_t  trk_z_o,
    output depth_post_pkg::fp16_t  trk_c_o
);

    depth_post_pkg::track_state_e state_q;

    // counters hold the coordinate of the next pixel
    depth_post_pkg::coord_t col_q;
    depth_post_pkg::coord_t row_q;

    depth_post_pkg::coord_t cur_col;
    depth_post_pkg::coord_t cur_row;
    depth_post_pkg::coord_t next_col;
    depth_post_pkg::coord_t next_row;
    depth_post_pkg::coord_t last_col;
    depth_post_pkg::coord_t last_row;
    logic                   accept;

    assign last_col = roi_width_i - 16'd1;
    assign last_row = roi_height_i - 16'd1;

    ////////////////////////////////////////////////////////////
    // coordinate of this pixel and of the one after it
    always_comb begin
        accept = pix_valid_i && (pix_sof_i || (state_q == depth_post_pkg::TRK_RUN));

        // frame start forces the origin from any state
        cur_col = pix_sof_i ? '0 : col_q;
        cur_row = pix_sof_i ? '0 : row_q;

        next_col = cur_col + 16'd1;
        next_row = cur_row;
        if (cur_col >= last_col) begin
            next_col = '0;
            next_row = cur_row + 16'd1;
            if (cur_row >= last_row) begin
                next_row = '0;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // state and counters
    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            state_q     <= depth_post_pkg::TRK_IDLE;
            col_q       <= '0;
            row_q       <= '0;
            trk_valid_o <= 1'b0;
        end else begin
            trk_valid_o <= accept;
            if (pix_valid_i && pix_sof_i) begin
                state_q <= depth_post_pkg::TRK_RUN;
            end
            if (accept) begin
                col_q <= next_col;
                row_q <= next_row;
            end
        end
    end

    // coordinates travel with the pixel data
    always_ff @(posedge core_clk) begin
        if (accept) begin
            trk_col_o <= cur_col;
            trk_row_o <= cur_row;
            trk_z_o   <= pix_z_i;
            trk_c_o   <= pix_c_i;
        end
    end

    // column is checked against the width the pixel was tracked with
    a_col_in_roi: assert property (
        @(posedge core_clk) disable iff (sys_reset)
        trk_valid_o |-> (trk_col_o < $past(roi_width_i))
    );

endmodule

// File: rtl/confidence_gate.sv
`include "depth_post_settings.svh"

module confidence_gate (
    input  logic                   core_clk,
    input  logic                   sys_reset,
    input  logic                   trk_valid_i,
    input  depth_post_pkg::coord_t trk_col_i,
    input  depth_post_pkg::coord_t trk_row_i,
    input  depth_post_pkg::fp16_t  trk_z_i,
    input  depth_post_pkg::fp16_t  trk_c_i,
    input  depth_post_pkg::fp16_t  conf_threshold_i,
    output logic                   out_valid_o,
    output depth_post_pkg::coord_t out_col_o,
    output depth_post_pkg::coord_t out_row_o,
    output depth_post_pkg::fp16_t  out_z_o
);

    logic                  conf_ok;
    depth_post_pkg::fp16_t gated_z;

    // confidence compared as a plain unsigned pattern
    assign conf_ok = (trk_c_i >= conf_threshold_i);
    assign gated_z = conf_ok ? trk_z_i : `DP_Z_INVALID;

    ////////////////////////////////////////////////////////////
    // output stage
    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            out_valid_o <= 1'b0;
        end else begin
            out_valid_o <= trk_valid_i;
        end
    end

    always_ff @(posedge core_clk) begin
        if (trk_valid_i) begin
            out_col_o <= trk_col_i;
            out_row_o <= trk_row_i;
            out_z_o   <= gated_z;
        end
    end

endmodule

// File: rtl/depth_post_top.sv
module depth_post_top (
    input  logic                       core_clk,
    input  logic                       sys_reset,

    // host command link
    input  depth_post_pkg::link_byte_t link_byte_i,
    input  logic                       link_strobe_i,

    // incoming pixel stream
    input  logic                       pix_valid_i,
    input  logic                       pix_sof_i,
    input  depth_post_pkg::fp16_t      pix_z_i,
    input  depth_post_pkg::fp16_t      pix_c_i,

    // gated pixel stream two cycles behind the input
    output logic                       out_valid_o,
    output depth_post_pkg::coord_t     out_col_o,
    output depth_post_pkg::coord_t     out_row_o,
    output depth_post_pkg::fp16_t      out_z_o
);

    ////////////////////////////////////////////////////////////
    // command path
    depth_post_pkg::cmd_addr_t cmd_addr;
    depth_post_pkg::cmd_data_t cmd_data;
    logic                      cmd_strobe;
    depth_post_pkg::fp16_t     conf_threshold;
    depth_post_pkg::coord_t    roi_width;
    depth_post_pkg::coord_t    roi_height;

    command_word_assembler u_cmd_asm (
        .core_clk     (core_clk),
        .sys_reset    (sys_reset),
        .link_byte_i  (link_byte_i),
        .link_strobe_i(link_strobe_i),
        .cmd_addr_o   (cmd_addr),
        .cmd_data_o   (cmd_data),
        .cmd_strobe_o (cmd_strobe)
    );

    constants_regfile u_regfile (
        .core_clk        (core_clk),
        .sys_reset       (sys_reset),
        .cmd_addr_i      (cmd_addr),
        .cmd_data_i      (cmd_data),
        .cmd_strobe_i    (cmd_strobe),
        .conf_threshold_o(conf_threshold),
        .roi_width_o     (roi_width),
        .roi_height_o    (roi_height)
    );

    ////////////////////////////////////////////////////////////
    // pixel path
    logic                   trk_valid;
    depth_post_pkg::coord_t trk_col;
    depth_post_pkg::coord_t trk_row;
    depth_post_pkg::fp16_t  trk_z;
    depth_post_pkg::fp16_t  trk_c;

    pixel_coord_tracker u_tracker (
        .core_clk    (core_clk),
        .sys_reset   (sys_reset),
        .pix_valid_i (pix_valid_i),
        .pix_sof_i   (pix_sof_i),
        .pix_z_i     (pix_z_i),
        .pix_c_i     (pix_c_i),
        .roi_width_i (roi_width),
        .roi_height_i(roi_height),
        .trk_valid_o (trk_valid),
        .trk_col_o   (trk_col),
        .trk_row_o   (trk_row),
        .trk_z_o     (trk_z),
        .trk_c_o     (trk_c)
    );

    confidence_gate u_gate (
        .core_clk        (core_clk),
        .sys_reset       (sys_reset),
        .trk_valid_i     (trk_valid),
        .trk_col_i       (trk_col),
        .trk_row_i       (trk_row),
        .trk_z_i         (trk_z),
        .trk_c_i         (trk_c),
        .conf_threshold_i(conf_threshold),
        .out_valid_o     (out_valid_o),
        .out_col_o       (out_col_o),
        .out_row_o       (out_row_o),
        .out_z_o         (out_z_o)
    );

endmodule

// File: dv/depth_post_tb.sv
`include "depth_post_settings.svh"

module depth_post_tb;

    timeunit 1ns;
    timeprecision 100ps;

    logic                       core_clk;
    logic                       sys_reset;
    depth_post_pkg::link_byte_t link_byte_i;
    logic                       link_strobe_i;
    logic                       pix_valid_i;
    logic                       pix_sof_i;
    depth_post_pkg::fp16_t      pix_z_i;
    depth_post_pkg::fp16_t      pix_c_i;
    logic                       out_valid_o;
    depth_post_pkg::coord_t     out_col_o;
    depth_post_pkg::coord_t     out_row_o;
    depth_post_pkg::fp16_t      out_z_o;

    // stimulus table with one entry per phase
    string                     tb_name[$];
    bit                        tb_is_cmd[$];
    depth_post_pkg::cmd_addr_t tb_addr[$];
    depth_post_pkg::cmd_data_t tb_data[$];
    bit                        tb_sof[$];
    depth_post_pkg::fp16_t     tb_z[$];
    depth_post_pkg::fp16_t     tb_c[$];
    bit                        tb_rgap[$];

    // expected outputs in order of arrival
    depth_post_pkg::coord_t exp_col[$];
    depth_post_pkg::coord_t exp_row[$];
    depth_post_pkg::fp16_t  exp_z[$];
    int                     exp_cyc[$];
    int                     exp_idx[$];

    // reference model state
    depth_post_pkg::fp16_t  m_thr;
    depth_post_pkg::coord_t m_width;
    depth_post_pkg::coord_t m_height;
    depth_post_pkg::coord_t m_col;
    depth_post_pkg::coord_t m_row;
    bit                     m_run;

    int     cycle_cnt     = 0;
    int     err_cnt       = 0;
    int     chk_cnt       = 0;
    int     timeout_limit = 1000;
    integer seed          = 5984;

    depth_post_top dut_i (
        .core_clk     (core_clk),
        .sys_reset    (sys_reset),
        .link_byte_i  (link_byte_i),
        .link_strobe_i(link_strobe_i),
        .pix_valid_i  (pix_valid_i),
        .pix_sof_i    (pix_sof_i),
        .pix_z_i      (pix_z_i),
        .pix_c_i      (pix_c_i),
        .out_valid_o  (out_valid_o),
        .out_col_o    (out_col_o),
        .out_row_o    (out_row_o),
        .out_z_o      (out_z_o)
    );

    initial begin
        core_clk = 1'b0;
        forever begin
            #2 core_clk = ~core_clk;
        end
    end

    task automatic finish_run();
        $display("checks: %0d  errors: %0d", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    endtask

    always @(posedge core_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= timeout_limit) begin
            $display("timeout: stimulus did not complete within %0d cycles", timeout_limit);
            err_cnt = err_cnt + 1;
            finish_run();
        end
    end

    ////////////////////////////////////////////////////////////
    // table construction
    task automatic add_cmd(input string name, input depth_post_pkg::cmd_addr_t addr,
                           input depth_post_pkg::cmd_data_t data);
        tb_name.push_back(name);
        tb_is_cmd.push_back(1'b1);
        tb_addr.push_back(addr);
        tb_data.push_back(data);
        tb_sof.push_back(1'b0);
        tb_z.push_back(16'h0000);
        tb_c.push_back(16'h0000);
        tb_rgap.push_back(1'b0);
    endtask

    task automatic add_pix(input string name, input bit sof, input depth_post_pkg::fp16_t z,
                           input depth_post_pkg::fp16_t c, input bit rgap);
        tb_name.push_back(name);
        tb_is_cmd.push_back(1'b0);
        tb_addr.push_back(16'h0000);
        tb_data.push_back(32'h0000_0000);
        tb_sof.push_back(sof);
        tb_z.push_back(z);
        tb_c.push_back(c);
        tb_rgap.push_back(rgap);
    endtask

    task automatic build_table();
        int i;
        // nothing may come out before the first frame start
        for (i = 0; i < 3; i++) begin
            add_pix("drop_before_sof", 1'b0, 16'(32'h0100 + i), 16'h3C00, 1'b0);
        end
        // threshold 0 lets every confidence through including zero
        for (i = 0; i < 6; i++) begin
            add_pix("default_pass", i == 0, 16'(32'h1100 + i), 16'(i), 1'b0);
        end
        // junk in the upper data half must be ignored
        add_cmd("set_threshold", `DP_ADDR_CONFIDENCE, 32'hA5A5_3C00);
        add_pix("conf_below", 1'b0, 16'h1200, 16'h3800, 1'b0);
        add_pix("conf_equal", 1'b0, 16'h1201, 16'h3C00, 1'b0);
        add_pix("conf_above", 1'b0, 16'h1202, 16'h4000, 1'b0);
        add_pix("conf_just_below", 1'b0, 16'h1203, 16'h3BFF, 1'b0);
        add_cmd("set_width", `DP_ADDR_ROI_WIDTH, 32'd5);
        add_cmd("set_height", `DP_ADDR_ROI_HEIGHT, 32'd3);
        // full 5x3 frame plus one pixel to see the wrap
        for (i = 0; i < 16; i++) begin
            if (i == 7) begin
                add_cmd("width_zero", `DP_ADDR_ROI_WIDTH, 32'h0001_0000);
                add_cmd("unknown_addr", 16'h0009, 32'd2);
            end
            add_pix("roi_walk", i == 0, 16'(32'h1300 + i),
                    (i % 4 == 3) ? 16'h3000 : 16'h3C00, 1'b0);
        end
        for (i = 0; i < 3; i++) begin
            add_pix("resync_lead", 1'b0, 16'(32'h1400 + i), 16'h3C00, 1'b0);
        end
        add_pix("mid_frame_sof", 1'b1, 16'h1480, 16'h3C00, 1'b0);
        for (i = 0; i < 12; i++) begin
            add_pix("random_gap", 1'b0, 16'(32'h1500 + i),
                    (i % 2 == 0) ? 16'h3A00 : 16'h3E00, 1'b1);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // reference model
    task automatic model_command(input depth_post_pkg::cmd_addr_t addr,
                                 input depth_post_pkg::cmd_data_t data);
        case (addr)
            `DP_ADDR_CONFIDENCE: begin
                m_thr = data[15:0];
            end
            `DP_ADDR_ROI_WIDTH: begin
                if (data[15:0] != 16'h0000) begin
                    m_width = data[15:0];
                end
            end
            `DP_ADDR_ROI_HEIGHT: begin
                if (data[15:0] != 16'h0000) begin
                    m_height = data[15:0];
                end
            end
            default: begin
            end
        endcase
    endtask

    task automatic model_pixel(input int idx);
        if (tb_sof[idx]) begin
            m_run = 1'b1;
            m_col = 16'd0;
            m_row = 16'd0;
        end
        if (m_run) begin
            exp_col.push_back(m_col);
            exp_row.push_back(m_row);
            exp_z.push_back((tb_c[idx] >= m_thr) ? tb_z[idx] : `DP_Z_INVALID);
            exp_cyc.push_back(cycle_cnt);
            exp_idx.push_back(idx);
            // step to the next raster position
            if (m_col == m_width - 16'd1) begin
                m_col = 16'd0;
                if (m_row == m_height - 16'd1) begin
                    m_row = 16'd0;
                end else begin
                    m_row = m_row + 16'd1;
                end
            end else begin
                m_col = m_col + 16'd1;
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // input drivers
    task automatic drive_idle();
        @(posedge core_clk);
        #1;
        link_strobe_i = 1'b0;
        pix_valid_i   = 1'b0;
        pix_sof_i     = 1'b0;
    endtask

    task automatic drive_byte(input depth_post_pkg::link_byte_t b);
        @(posedge core_clk);
        #1;
        link_byte_i   = b;
        link_strobe_i = 1'b1;
        pix_valid_i   = 1'b0;
        pix_sof_i     = 1'b0;
    endtask

    task automatic apply_command(input int idx);
        depth_post_pkg::cmd_addr_t addr;
        depth_post_pkg::cmd_data_t data;
        addr = tb_addr[idx];
        data = tb_data[idx];
        // address before data and msb first
        drive_byte(addr[15:8]);
        drive_byte(addr[7:0]);
        drive_byte(data[31:24]);
        drive_byte(data[23:16]);
        drive_byte(data[15:8]);
        drive_byte(data[7:0]);
        repeat (8) drive_idle();
        model_command(addr, data);
    endtask

    task automatic apply_pixel(input int idx);
        int gap;
        @(posedge core_clk);
        #1;
        link_strobe_i = 1'b0;
        pix_valid_i   = 1'b1;
        pix_sof_i     = tb_sof[idx];
        pix_z_i       = tb_z[idx];
        pix_c_i       = tb_c[idx];
        model_pixel(idx);
        gap = 0;
        if (tb_rgap[idx]) begin
            gap = $unsigned($random(seed)) % 3;
        end
        repeat (gap) drive_idle();
    endtask

    ////////////////////////////////////////////////////////////
    // output checker sampling on the falling edge
    always @(negedge core_clk) begin : check_outputs
        depth_post_pkg::coord_t e_col;
        depth_post_pkg::coord_t e_row;
        depth_post_pkg::fp16_t  e_z;
        int                     e_cyc;
        int                     e_idx;
        if (!sys_reset && out_valid_o) begin
            if (exp_col.size() == 0) begin
                $display("ERROR: unexpected output pixel at cycle %0d", cycle_cnt);
                err_cnt = err_cnt + 1;
            end else begin
                e_col = exp_col.pop_front();
                e_row = exp_row.pop_front();
                e_z   = exp_z.pop_front();
                e_cyc = exp_cyc.pop_front();
                e_idx = exp_idx.pop_front();
                chk_cnt = chk_cnt + 1;
                assert (out_col_o == e_col && out_row_o == e_row && out_z_o == e_z) else begin
                    $display("CHECK FAILED %s: expected (%0d,%0d) z 0x%h actual (%0d,%0d) z 0x%h",
                             tb_name[e_idx], e_col, e_row, e_z,
                             out_col_o, out_row_o, out_z_o);
                    err_cnt = err_cnt + 1;
                end
                assert (cycle_cnt - e_cyc == 2) else begin
                    $display("CHECK FAILED %s latency: expected 2 cycles, actual %0d",
                             tb_name[e_idx], cycle_cnt - e_cyc);
                    err_cnt = err_cnt + 1;
                end
            end
        end
    end

    initial begin
        int idx;
        int drain;
        sys_reset     = 1'b1;
        link_byte_i   = 8'h00;
        link_strobe_i = 1'b0;
        pix_valid_i   = 1'b0;
        pix_sof_i     = 1'b0;
        pix_z_i       = 16'h0000;
        pix_c_i       = 16'h0000;
        m_thr         = `DP_CONF_DEFAULT;
        m_width       = `DP_ROI_WIDTH_DEFAULT;
        m_height      = `DP_ROI_HEIGHT_DEFAULT;
        m_col         = 16'd0;
        m_row         = 16'd0;
        m_run         = 1'b0;
        build_table();
        timeout_limit = 16 + 20 * tb_name.size() + 100;
        repeat (16) @(posedge core_clk);
        #1;
        sys_reset = 1'b0;
        for (idx = 0; idx < tb_name.size(); idx++) begin
            if (tb_is_cmd[idx]) begin
                apply_command(idx);
            end else begin
                apply_pixel(idx);
            end
        end
        drive_idle();
        // bounded wait for the pipeline to empty
        drain = 0;
        while (exp_col.size() != 0 && drain < 10) begin
            @(posedge core_clk);
            drain = drain + 1;
        end
        repeat (4) @(posedge core_clk);
        assert (exp_col.size() == 0) else begin
            $display("ERROR: %0d expected output pixels never appeared", exp_col.size());
            err_cnt = err_cnt + 1;
        end
        finish_run();
    end

endmodule

// File: sources.f
+incdir+rtl
rtl/depth_post_pkg.sv
rtl/command_word_assembler.sv
rtl/constants_regfile.sv
rtl/pixel_coord_tracker.sv
rtl/confidence_gate.sv
rtl/depth_post_top.sv
dv/depth_post_tb.sv

// File: Makefile
TOP := depth_post_tb
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		-f sources.f --top-module $(TOP) --Mdir obj_dir

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

lint:
	verilator --lint-only --timing --assert --timescale 1ns/100ps \
		-f sources.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)
